//--- aes_core.f
+incdir+source
+incdir+tb
source/aes_pkg.sv
source/aes_ctrl.sv
source/aes_round_ctr.sv
source/aes_round.sv
source/aes_datapath.sv
source/aes_core.sv
tb/tb_aes_core.sv

//--- Makefile
TOP := tb_aes_core

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) \
		-f aes_core.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- tb/tb_aes_tasks.svh
`ifndef TB_AES_TASKS_SVH
`define TB_AES_TASKS_SVH

// FIPS-197 appendix C vectors. Keys are left-aligned in 256 bits.
localparam logic [127:0] PLAIN  = 128'h00112233445566778899aabbccddeeff;
localparam logic [255:0] KEY128 = {128'h000102030405060708090a0b0c0d0e0f, 128'h0};
localparam logic [255:0] KEY192 = {192'h000102030405060708090a0b0c0d0e0f1011121314151617,
                                   64'h0};
localparam logic [255:0] KEY256 =
  256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
localparam logic [127:0] CT128  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
localparam logic [127:0] CT192  = 128'hdda97ca4864cdfe06eaf70a0ec0d7191;
localparam logic [127:0] CT256  = 128'h8ea2b7ca516745bfeafc49904b496089;

// Round constants, indexed from 1.
localparam logic [1:10][7:0] RCON = {8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
                                     8'h20, 8'h40, 8'h80, 8'h1b, 8'h36};

function automatic logic [31:0] sub_word(input logic [31:0] w);
  return {aes_pkg::sbox(w[31:24]), aes_pkg::sbox(w[23:16]),
          aes_pkg::sbox(w[15:8]), aes_pkg::sbox(w[7:0])};
endfunction

// Standard key expansion. Round key r is words 4r to 4r+3, first word on top.
function automatic aes_pkg::key_sched_t expand_key(input logic [255:0] key,
                                                   input aes_pkg::key_size_t ks);
  logic [31:0]         w [0:59];
  logic [31:0]         t;
  aes_pkg::key_sched_t sched;
  int                  nk;
  int                  nw;
  nk    = (ks == 2'b00) ? 4 : ((ks == 2'b01) ? 6 : 8);
  nw    = 4 * (nk + 7);
  sched = '0;
  for (int i = 0; i < nw; i++) begin
    if (i < nk) begin
      w[i] = key[255-32*i -: 32];
    end else begin
      t = w[i-1];
      if (i % nk == 0) begin
        t = sub_word({t[23:0], t[31:24]}) ^ {RCON[i/nk], 24'h0};
      end else if (nk == 8 && i % nk == 4) begin
        t = sub_word(t);
      end
      w[i] = w[i-nk] ^ t;
    end
  end
  for (int r = 0; r < nw / 4; r++) begin
    sched[128*r +: 128] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
  end
  return sched;
endfunction

// Offers a block and returns just after its accept edge.
// The inputs are cleared afterwards and the size code is flipped to one with
// another round count, so a result can only come from captured data.
task automatic send_block(input logic [127:0] pt, input aes_pkg::key_size_t ks,
                          input logic [255:0] key);
  int n;
  n = 0;
  @(posedge eph1);
  in_valid_i   <= 1'b1;
  plain_text_i <= pt;
  key_size_i   <= ks;
  key_words_i  <= expand_key(key, ks);
  @(negedge eph1);
  while (!in_ready_o && n < WAIT_LIMIT) begin
    @(negedge eph1);
    n++;
  end
  if (!in_ready_o) begin
    stop_run("The DUT never accepted an offered block.");
  end else begin
    @(posedge eph1);
    in_valid_i   <= 1'b0;
    plain_text_i <= '0;
    key_size_i   <= ~ks;
    key_words_i  <= '0;
  end
endtask

// Counts edges after the accept edge until out_valid_o is seen.
// in_ready_o must stay low for the whole time the block is in the core.
task automatic expect_result(input string test, input logic [127:0] exp, input int nr);
  int lat;
  lat = 0;
  do begin
    @(posedge eph1);
    lat++;
    @(negedge eph1);
    check_value(test, 128'(1'b0), 128'(in_ready_o));
  end while (!out_valid_o && lat < WAIT_LIMIT);
  if (!out_valid_o) begin
    stop_run("out_valid_o never rose after a block was accepted.");
  end else begin
    check_value(test, 128'(nr), 128'(lat));
    check_value(test, exp, cipher_o);
  end
endtask

// With out_ready_i high the next edge takes the result.
task automatic confirm_taken(input string test);
  @(posedge eph1);
  @(negedge eph1);
  check_value(test, 128'(1'b0), 128'(out_valid_o));
  check_value(test, 128'(1'b1), 128'(in_ready_o));
endtask

task automatic run_vector(input string test, input aes_pkg::key_size_t ks,
                          input logic [255:0] key, input logic [127:0] exp, input int nr);
  send_block(PLAIN, ks, key);
  expect_result(test, exp, nr);
  confirm_taken(test);
endtask

task automatic test_reset();
  @(negedge eph1);
  check_value("test_reset", 128'(1'b0), 128'(out_valid_o));
  check_value("test_reset", 128'(1'b1), 128'(in_ready_o));
endtask

task automatic test_aes128();
  run_vector("test_aes128", 2'b00, KEY128, CT128, 10);
endtask

task automatic test_aes192();
  run_vector("test_aes192", 2'b01, KEY192, CT192, 12);
endtask

// Both 1x codes select the 256-bit key.
task automatic test_aes256();
  run_vector("test_aes256", 2'b10, KEY256, CT256, 14);
  run_vector("test_aes256", 2'b11, KEY256, CT256, 14);
endtask

// The result must hold still while out_ready_i is low.
task automatic test_backpressure();
  int stall;
  stall = 0;
  for (int i = 0; i < 4; i++) begin
    lfsr_q = lfsr_step(lfsr_q);
    stall  = stall * 2 + int'(lfsr_q[0]);
  end
  @(posedge eph1);
  out_ready_i <= 1'b0;
  send_block(PLAIN, 2'b00, KEY128);
  expect_result("test_backpressure", CT128, 10);
  for (int i = 0; i < stall; i++) begin
    @(posedge eph1);
    @(negedge eph1);
    check_value("test_backpressure", CT128, cipher_o);
    check_value("test_backpressure", 128'(1'b1), 128'(out_valid_o));
    check_value("test_backpressure", 128'(1'b0), 128'(in_ready_o));
  end
  @(posedge eph1);
  out_ready_i <= 1'b1;
  confirm_taken("test_backpressure");
endtask

// Each block is offered on the edge that takes the one before it.
task automatic test_back_to_back();
  send_block(PLAIN, 2'b10, KEY256);
  expect_result("test_back_to_back", CT256, 14);
  send_block(PLAIN, 2'b00, KEY128);
  expect_result("test_back_to_back", CT128, 10);
  send_block(PLAIN, 2'b01, KEY192);
  expect_result("test_back_to_back", CT192, 12);
  confirm_taken("test_back_to_back");
endtask

`endif

//--- tb/tb_aes_core.sv
`timescale 1ns/1ps

module tb_aes_core;

  // Cycle limit for every wait loop in the testbench.
  localparam int WAIT_LIMIT = 64;

  logic                eph1;
  logic                rst_i;
  logic                in_valid_i;
  logic                in_ready_o;
  aes_pkg::block_t     plain_text_i;
  aes_pkg::key_size_t  key_size_i;
  aes_pkg::key_sched_t key_words_i;
  logic                out_valid_o;
  logic                out_ready_i;
  aes_pkg::block_t     cipher_o;

  // LFSR state, stepped once for every random bit.
  logic [31:0] lfsr_q;

  aes_core u_dut (
    .eph1         (eph1),
    .rst_i        (rst_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .plain_text_i (plain_text_i),
    .key_size_i   (key_size_i),
    .key_words_i  (key_words_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .cipher_o     (cipher_o)
  );

  // 4 ns clock period.
  initial begin
    eph1 = 1'b0;
    forever #2 eph1 = ~eph1;
  end

  // ----------------------------------------
  // Random bits and checking
  // ----------------------------------------

  // Taps 32, 22, 2 and 1 give a maximal-length sequence.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic stop_run(input string why);
    $display("** FAIL **");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string test, input logic [127:0] exp,
                             input logic [127:0] act);
    if (act !== exp) begin
      $display("Error in %s: expected %h, actual %h", test, exp, act);
      stop_run("A DUT output did not match its expected value.");
    end
  endtask

  `include "tb_aes_tasks.svh"

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    rst_i        = 1'b1;
    in_valid_i   = 1'b0;
    plain_text_i = '0;
    key_size_i   = '0;
    key_words_i  = '0;
    out_ready_i  = 1'b1;
    lfsr_q       = 32'h1b47_8ad5;
    // Reset is held for eight clock cycles.
    repeat (8) @(posedge eph1);
    rst_i <= 1'b0;
    test_reset();
    test_aes128();
    test_aes192();
    test_aes256();
    test_backpressure();
    test_back_to_back();
    $display("** PASS **");
    $finish;
  end

endmodule

//--- source/aes_core.sv
`timescale 1ns/1ps

module aes_core (
  input  logic                eph1,
  input  logic                rst_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  aes_pkg::block_t     plain_text_i,
  input  aes_pkg::key_size_t  key_size_i,
  input  aes_pkg::key_sched_t key_words_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output aes_pkg::block_t     cipher_o
);

  // Accept strobe and round enable from the FSM.
  logic                start;
  logic                run;
  // Round position from the counter.
  aes_pkg::round_idx_t round_idx;
  logic                last_round;

  // The FSM owns both handshakes.
  aes_ctrl u_ctrl (
    .eph1         (eph1),
    .rst_i        (rst_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .last_round_i (last_round),
    .start_o      (start),
    .run_o        (run)
  );

  aes_round_ctr u_round_ctr (
    .eph1         (eph1),
    .rst_i        (rst_i),
    .start_i      (start),
    .run_i        (run),
    .key_size_i   (key_size_i),
    .round_idx_o  (round_idx),
    .last_round_o (last_round)
  );

  // The state register doubles as the ciphertext output.
  aes_datapath u_datapath (
    .eph1         (eph1),
    .rst_i        (rst_i),
    .start_i      (start),
    .run_i        (run),
    .plain_text_i (plain_text_i),
    .key_words_i  (key_words_i),
    .round_idx_i  (round_idx),
    .last_round_i (last_round),
    .cipher_o     (cipher_o)
  );

endmodule

//--- source/aes_datapath.sv
`timescale 1ns/1ps
`include "aes_cfg.svh"

module aes_datapath (
  input  logic                eph1,
  input  logic                rst_i,
  input  logic                start_i,
  input  logic                run_i,
  input  aes_pkg::block_t     plain_text_i,
  input  aes_pkg::key_sched_t key_words_i,
  input  aes_pkg::round_idx_t round_idx_i,
  input  logic                last_round_i,
  output aes_pkg::block_t     cipher_o
);

  aes_pkg::key_sched_t key_sched_q;
  aes_pkg::block_t     state_q;
  aes_pkg::round_key_t round_key;
  aes_pkg::block_t     round_out;

  // The whole schedule is held for the block, so new input may change freely.
  always_ff @(posedge eph1) begin
    if (start_i) begin
      key_sched_q <= key_words_i;
    end
  end

  // Round key select. An index past the schedule gives zero.
  always_comb begin
    round_key = '0;
    for (int i = 0; i < `AES_MAX_KEYS; i++) begin
      if (round_idx_i == aes_pkg::round_idx_t'(i)) begin
        round_key = key_sched_q[i*`AES_BLOCK_W +: `AES_BLOCK_W];
      end
    end
  end

  aes_round u_round (
    .state_i     (state_q),
    .round_key_i (round_key),
    .final_i     (last_round_i),
    .state_o     (round_out)
  );

  // Whitening takes key 0 straight from the input, since the schedule is
  // captured on that same edge. The register holds outside start and run,
  // which keeps the ciphertext steady in DONE.
  always_ff @(posedge eph1) begin
    if (rst_i) begin
      state_q <= '0;
    end else if (start_i) begin
      state_q <= plain_text_i ^ key_words_i[`AES_BLOCK_W-1:0];
    end else if (run_i) begin
      state_q <= round_out;
    end
  end

  assign cipher_o = state_q;

endmodule

//--- source/aes_round.sv
`timescale 1ns/1ps

module aes_round (
  input  aes_pkg::block_t     state_i,
  input  aes_pkg::round_key_t round_key_i,
  input  logic                final_i,
  output aes_pkg::block_t     state_o
);

  // Byte views of the state. Byte 15 is row 0 of column 0, so row r of
  // column c is byte 15-(4c+r).
  logic [15:0][7:0] in_b;
  logic [15:0][7:0] sub_b;
  logic [15:0][7:0] shift_b;
  logic [15:0][7:0] mix_b;

  assign in_b = state_i;

  // ----------------------------------------
  // SubBytes and ShiftRows
  // ----------------------------------------

  // Every byte goes through the S-box on its own.
  for (genvar i = 0; i < 16; i++) begin : g_sub
    assign sub_b[i] = aes_pkg::sbox(in_b[i]);
  end

  // Row r rotates left by r columns.
  // Output (r, c) takes input (r, (c+r) mod 4).
  for (genvar c = 0; c < 4; c++) begin : g_shift_col
    for (genvar r = 0; r < 4; r++) begin : g_shift_row
      assign shift_b[15-(4*c+r)] = sub_b[15-(4*((c+r)%4)+r)];
    end
  end

  // ----------------------------------------
  // MixColumns
  // ----------------------------------------

  // Each column is multiplied by the circulant with first row 2,3,1,1.
  // A times-3 term is the doubled byte XOR the byte itself.
  for (genvar c = 0; c < 4; c++) begin : g_mix_col
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;

    assign a0 = shift_b[15-4*c];
    assign a1 = shift_b[14-4*c];
    assign a2 = shift_b[13-4*c];
    assign a3 = shift_b[12-4*c];

    assign mix_b[15-4*c] = aes_pkg::xtime(a0) ^ aes_pkg::xtime(a1) ^ a1 ^ a2 ^ a3;
    assign mix_b[14-4*c] = a0 ^ aes_pkg::xtime(a1) ^ aes_pkg::xtime(a2) ^ a2 ^ a3;
    assign mix_b[13-4*c] = a0 ^ a1 ^ aes_pkg::xtime(a2) ^ aes_pkg::xtime(a3) ^ a3;
    assign mix_b[12-4*c] = aes_pkg::xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_pkg::xtime(a3);
  end

  // ----------------------------------------
  // AddRoundKey
  // ----------------------------------------

  // The last round leaves out MixColumns.
  // The key is laid out like the state, so a plain XOR adds it.
  assign state_o = (final_i ? shift_b : mix_b) ^ round_key_i;

endmodule

//--- source/aes_round_ctr.sv
`timescale 1ns/1ps
`include "aes_cfg.svh"

module aes_round_ctr (
  input  logic                eph1,
  input  logic                rst_i,
  input  logic                start_i,
  input  logic                run_i,
  input  aes_pkg::key_size_t  key_size_i,
  output aes_pkg::round_idx_t round_idx_o,
  output logic                last_round_o
);

  aes_pkg::round_idx_t round_idx_q;
  aes_pkg::key_size_t  key_size_q;
  aes_pkg::round_idx_t num_rounds;

  // ----------------------------------------
  // Round index and captured key size
  // ----------------------------------------

  // The whitening step uses key 0 on the accept edge, so the first real
  // round is 1. The index then points straight at its round key.
  // After the final round it steps once more to Nr+1, which is harmless
  // because nothing reads it until the next accept reloads it.
  always_ff @(posedge eph1) begin
    if (rst_i) begin
      round_idx_q <= '0;
      key_size_q  <= '0;
    end else if (start_i) begin
      round_idx_q <= aes_pkg::round_idx_t'(1);
      key_size_q  <= key_size_i;
    end else if (run_i) begin
      round_idx_q <= round_idx_q + aes_pkg::round_idx_t'(1);
    end
  end

  // ----------------------------------------
  // Final round detect
  // ----------------------------------------

  // Both 1x codes mean a 256-bit key.
  always_comb begin
    case (key_size_q)
      2'b00:   num_rounds = aes_pkg::round_idx_t'(`AES_NR_128);
      2'b01:   num_rounds = aes_pkg::round_idx_t'(`AES_NR_192);
      default: num_rounds = aes_pkg::round_idx_t'(`AES_NR_256);
    endcase
  end

  assign round_idx_o  = round_idx_q;
  // High during the round that skips MixColumns.
  assign last_round_o = (round_idx_q == num_rounds);

endmodule

//--- source/aes_ctrl.sv
`timescale 1ns/1ps

module aes_ctrl (
  input  logic eph1,
  input  logic rst_i,
  input  logic in_valid_i,
  output logic in_ready_o,
  output logic out_valid_o,
  input  logic out_ready_i,
  input  logic last_round_i,
  output logic start_o,
  output logic run_o
);

  aes_pkg::ctrl_state_t state_q;
  aes_pkg::ctrl_state_t state_d;

  // ----------------------------------------
  // Handshake decode
  // ----------------------------------------

  // The core takes a new block only while idle.
  assign in_ready_o  = (state_q == aes_pkg::IDLE);
  // The ciphertext is offered for as long as the FSM sits in DONE.
  assign out_valid_o = (state_q == aes_pkg::DONE);
  // Accept condition, shared by the counter and the datapath.
  assign start_o     = in_valid_i && in_ready_o;
  // One round is applied on every edge spent in RUN.
  assign run_o       = (state_q == aes_pkg::RUN);

  // ----------------------------------------
  // Next state
  // ----------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      aes_pkg::IDLE: if (start_o) state_d = aes_pkg::RUN;
      // The final round is written on the same edge that leaves RUN.
      aes_pkg::RUN:  if (last_round_i) state_d = aes_pkg::DONE;
      // Stay here under back-pressure; the state register holds the result.
      aes_pkg::DONE: if (out_ready_i) state_d = aes_pkg::IDLE;
      default:       state_d = aes_pkg::IDLE;
    endcase
  end

  always_ff @(posedge eph1) begin
    if (rst_i) begin
      state_q <= aes_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- source/aes_pkg.sv
`include "aes_cfg.svh"

package aes_pkg;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------

  // Byte 15 sits in the top bits and the bytes run column-major, so the
  // first byte of the standard's input string is row 0 of column 0.
  typedef logic [`AES_BLOCK_W-1:0] block_t;
  typedef logic [`AES_BLOCK_W-1:0] round_key_t;

  // Round key i lives at bits [128*i +: 128]; the whitening key is at the bottom.
  typedef logic [`AES_MAX_KEYS*`AES_BLOCK_W-1:0] key_sched_t;

  // Code 00 is a 128-bit key, 01 is 192-bit, and both 1x codes are 256-bit.
  typedef logic [1:0] key_size_t;

  typedef logic [`AES_ROUND_W-1:0] round_idx_t;

  // Controller states.
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    RUN  = 2'b01,
    DONE = 2'b10
  } ctrl_state_t;

  // ----------------------------------------
  // Byte functions
  // ----------------------------------------

  // Forward S-box, one row of sixteen entries per line.
  // Element 0 is the leftmost byte, so row x0 of the table comes first.
  localparam logic [0:255][7:0] SBOX_TABLE = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // The input byte is the table address.
  function automatic logic [7:0] sbox(input logic [7:0] b);
    return SBOX_TABLE[b];
  endfunction

  // Multiply by x in GF(2^8).
  // A carry out of bit 7 is reduced by the field polynomial.
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? `AES_XTIME_POLY : 8'h00);
  endfunction

endpackage

//--- source/aes_cfg.svh
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// ----------------------------------------
// AES core widths and round counts
// ----------------------------------------

// One state, block or round key is 128 bits.
`define AES_BLOCK_W 128

// A 256-bit key expands to fifteen round keys, whitening key included.
`define AES_MAX_KEYS 15

// Four bits index rounds 0 to 15.
`define AES_ROUND_W 4

// Round count for each key size.
`define AES_NR_128 10
`define AES_NR_192 12
`define AES_NR_256 14

// Low byte of x^8 + x^4 + x^3 + x + 1, folded back in after a doubling.
`define AES_XTIME_POLY 8'h1b

`endif
